// ==== tb.f ====
+incdir+dv
hw/wl_pkg.sv
hw/weight_fetch_ctrl.sv
hw/weight_pingpong_bank.sv
hw/weight_stream_reader.sv
hw/weight_load_top.sv
dv/weight_load_tb.sv

// ==== Makefile ====
# Verilator build for the weight load testbench

VERILATOR ?= verilator
TOP       ?= weight_load_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/weight_load_seq.svh ====
//////////////////////////////////////////////////////////////////////
// stimulus tasks, included inside weight_load_tb
//////////////////////////////////////////////////////////////////////

task automatic apply_reset();
  reset = 1'b1;
  repeat (4) @(negedge clk);                  // held for 4 cycles
  reset = 1'b0;
endtask

// one-cycle load_start pulse with the tile parameters
task automatic start_load(input wl_pkg::ddr_adr_t base, input wl_pkg::word_cnt_t num);
  @(negedge clk);
  base_adr   = base;
  num_words  = num;
  load_start = 1'b1;
  @(negedge clk);
  load_start = 1'b0;
endtask

// busy drops together with the done pulse, so a pulse already gone is not missed
task automatic wait_load_done();
  do
    @(negedge clk);
  while (load_busy);
endtask

// one streaming pass, gap_max idle cycles at most between steps
task automatic stream_pass(input int steps, input int gap_max);
  int gap;
  for (int i = 0; i < steps; i++)
  begin
    @(negedge clk);
    re_fm_en  = 1'b1;
    re_fm_end = (i == steps - 1);             // last step closes the pass
    gap = (gap_max > 0) ? $urandom_range(0, gap_max) : 0;
    if (gap > 0)
    begin
      @(negedge clk);
      re_fm_en  = 1'b0;
      re_fm_end = 1'b0;
      repeat (gap - 1) @(negedge clk);
    end
  end
  @(negedge clk);
  re_fm_en  = 1'b0;
  re_fm_end = 1'b0;
endtask

// hold back credits so requests stall, then let them flow again
task automatic starve_credits(input int delay, input int cycles);
  repeat (delay) @(posedge clk);              // model reads starve on the falling edge
  starve = 1'b1;
  repeat (cycles) @(posedge clk);
  starve = 1'b0;
endtask

// ==== dv/weight_load_tb.sv ====
`timescale 1ns/1ps

module weight_load_tb;

  localparam int DDR_CREDITS = 4;
  localparam int BANK_DEPTH  = 1024;
  localparam int MAX_CYCLES  = 4000;  // 88 words at up to ~12 cycles each plus streaming, x3 margin

  logic                 clk;
  logic                 reset;
  logic                 load_start;
  wl_pkg::ddr_adr_t     base_adr;
  wl_pkg::word_cnt_t    num_words;
  logic                 ddr_rd_en;
  wl_pkg::ddr_adr_t     ddr_rd_adr;
  logic                 ddr_credit;
  logic                 ddr_rd_valid;
  wl_pkg::weight_word_t ddr_rd_data;
  logic                 load_busy;
  logic                 load_done;
  logic                 re_fm_en;
  logic                 re_fm_end;
  wl_pkg::weight_word_t weights_vector;
  logic                 weights_valid;

  int                   cyc;        // cycle counter for the timeout
  logic                 starve;     // ddr model withholds credits
  int                   pend_crd;   // credits held back
  wl_pkg::ddr_adr_t     adr_q[$];   // outstanding requests, in order
  int                   due_q[$];   // cycle each request may return

  // scoreboard state
  int                   crd_used;   // requests not yet paid back
  wl_pkg::ddr_adr_t     exp_adr;
  int                   exp_num;
  int                   req_seen;
  int                   ret_seen;
  logic                 done_pend;
  wl_pkg::ddr_adr_t     last_base;  // load now in the fill bank
  int                   n_loads;
  wl_pkg::ddr_adr_t     drain_base; // load now in the drain bank
  logic                 drain_ok;
  int                   step;
  logic                 after_end;
  logic                 check_q;
  wl_pkg::weight_word_t exp_vec;

  weight_load_top #(
    .DDR_CREDITS (DDR_CREDITS),
    .BANK_DEPTH  (BANK_DEPTH)
  ) i_dut (
    .clk (clk), .reset (reset), .load_start (load_start),
    .base_adr (base_adr), .num_words (num_words),
    .ddr_rd_en (ddr_rd_en), .ddr_rd_adr (ddr_rd_adr), .ddr_credit (ddr_credit),
    .ddr_rd_valid (ddr_rd_valid), .ddr_rd_data (ddr_rd_data),
    .load_busy (load_busy), .load_done (load_done),
    .re_fm_en (re_fm_en), .re_fm_end (re_fm_end),
    .weights_vector (weights_vector), .weights_valid (weights_valid)
  );

  `include "weight_load_seq.svh"

  // byte k of the word at address a is a + k
  function automatic wl_pkg::weight_word_t model_word(input wl_pkg::ddr_adr_t a);
    wl_pkg::weight_word_t w;
    for (int k = 0; k < 8; k++)
    begin
      w[8*k +: 8] = 8'(a + 16'(k));
    end
    return w;
  endfunction

  task automatic report_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("Error: %s expected %0h actual %0h", name, exp, act);
    $display("Verification failed");
    $fatal(1, "check %s failed", name);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;                   // 20 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // ddr model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
    else if (!reset && ddr_rd_en)
    begin
      adr_q.push_back(ddr_rd_adr);
      due_q.push_back(cyc + $urandom_range(1, 6));  // 1 to 6 cycles latency
    end
  end

  always @(negedge clk)
  begin
    ddr_rd_valid = 1'b0;
    ddr_credit   = 1'b0;
    if (!reset && adr_q.size() > 0 && due_q[0] <= cyc)
    begin
      ddr_rd_valid = 1'b1;
      ddr_rd_data  = model_word(adr_q.pop_front());
      void'(due_q.pop_front());
      pend_crd++;
    end
    if (!starve && pend_crd > 0 && ($urandom_range(0, 3) != 0))  // sometimes late
    begin
      ddr_credit = 1'b1;
      pend_crd--;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (reset)
    begin
      crd_used  <= 0;
      req_seen  <= 0;
      ret_seen  <= 0;
      done_pend <= 1'b0;
      n_loads   <= 0;
      drain_ok  <= 1'b0;
      step      <= 0;
      after_end <= 1'b0;
      check_q   <= 1'b0;
    end
    else
    begin
      crd_used <= crd_used + int'(ddr_rd_en) - int'(ddr_credit);
      if (load_start)
      begin
        exp_adr    <= base_adr;
        exp_num    <= int'(num_words);
        req_seen   <= 0;
        ret_seen   <= 0;
        done_pend  <= 1'b1;
        last_base  <= base_adr;
        drain_base <= last_base;              // previous fill turns drain
        drain_ok   <= (n_loads > 0);
        n_loads    <= n_loads + 1;
      end
      else
      begin
        if (ddr_rd_en)
        begin
          exp_adr  <= exp_adr + 1'b1;
          req_seen <= req_seen + 1;
        end
        ret_seen <= ret_seen + int'(ddr_rd_valid);
        if (load_done)
          done_pend <= 1'b0;
      end
      if (re_fm_en)
      begin
        exp_vec   <= model_word(drain_base + 16'(step));
        step      <= re_fm_end ? 0 : step + 1;  // pass restarts at word 0
        after_end <= re_fm_end;
      end
      check_q <= re_fm_en && drain_ok;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> crd_used < DDR_CREDITS)
    else report_error("credit limit", DDR_CREDITS - 1, $sampled(crd_used));
  a_adr_seq: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> ddr_rd_adr == exp_adr)
    else report_error("address sequence", $sampled(exp_adr), $sampled(ddr_rd_adr));
  a_req_count: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> req_seen < exp_num)
    else report_error("request count", exp_num, $sampled(req_seen) + 1);
  a_done_count: assert property (@(posedge clk) disable iff (reset)
    load_done |-> ret_seen == exp_num)
    else report_error("words before done", exp_num, $sampled(ret_seen));
  a_done_timing: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_valid && (ret_seen + 1 == exp_num) |=> load_done)
    else report_error("done after last word", 1, 0);
  a_done_once: assert property (@(posedge clk) disable iff (reset)
    load_done |-> done_pend)
    else report_error("done pulses per load", 1, 2);
  a_busy_done: assert property (@(posedge clk) disable iff (reset)
    load_done |-> !load_busy)
    else report_error("busy after done", 0, 1);
  // busy from the cycle after start up to the done pulse, low otherwise
  a_busy_window: assert property (@(posedge clk) disable iff (reset)
    load_busy == (done_pend && !load_done))
    else report_error("busy window", $sampled(done_pend && !load_done),
                      $sampled(load_busy));
  a_valid_follow: assert property (@(posedge clk) disable iff (reset)
    re_fm_en |=> weights_valid)
    else report_error("valid after step", 1, 0);
  a_valid_only: assert property (@(posedge clk) disable iff (reset)
    weights_valid |-> $past(re_fm_en))
    else report_error("valid without step", 0, 1);
  a_vector: assert property (@(posedge clk) disable iff (reset)
    weights_valid && check_q |-> weights_vector == exp_vec)
    else report_error("read-back vector", $sampled(exp_vec), $sampled(weights_vector));
  a_restart: assert property (@(posedge clk) disable iff (reset)
    re_fm_en && after_end && drain_ok |=> weights_vector == model_word(drain_base))
    else report_error("pass restart", model_word($sampled(drain_base)),
                      $sampled(weights_vector));

  //////////////////////////////////////////////////////////////////////
  // test flow
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(52));
    cyc          = 0;
    starve       = 1'b0;
    pend_crd     = 0;
    reset        = 1'b1;
    load_start   = 1'b0;
    base_adr     = '0;
    num_words    = '0;
    ddr_credit   = 1'b0;
    ddr_rd_valid = 1'b0;
    ddr_rd_data  = '0;
    re_fm_en     = 1'b0;
    re_fm_end    = 1'b0;
    apply_reset();
    start_load(16'h0100, 11'd24);             // tile a
    wait_load_done();
    start_load(16'h2000, 11'd40);             // tile b loads while a streams
    fork
      starve_credits(6, 25);
      stream_pass(24, 2);
    join
    stream_pass(5, 0);                        // restart from word 0
    wait_load_done();
    start_load(16'hfff8, 11'd16);             // ddr address wraps
    stream_pass(40, 0);                       // tile b back to back
    wait_load_done();
    start_load(16'h0400, 11'd8);
    stream_pass(16, 1);                       // tile c
    wait_load_done();
    repeat (4) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== hw/weight_load_top.sv ====
`timescale 1ns/1ps

module weight_load_top #(
  parameter int WORD_BITS   = wl_pkg::WORD_BITS,
  parameter int DDR_CREDITS = 4,
  parameter int BANK_DEPTH  = 1024
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_start,     // swap banks, start a tile
  input  wl_pkg::ddr_adr_t     base_adr,
  input  wl_pkg::word_cnt_t    num_words,
  output logic                 ddr_rd_en,
  output wl_pkg::ddr_adr_t     ddr_rd_adr,
  input  logic                 ddr_credit,
  input  logic                 ddr_rd_valid,
  input  logic [WORD_BITS-1:0] ddr_rd_data,
  output logic                 load_busy,
  output logic                 load_done,
  input  logic                 re_fm_en,
  input  logic                 re_fm_end,
  output logic [WORD_BITS-1:0] weights_vector,
  output logic                 weights_valid
);

  // fetch to bank
  logic                 buf_wr_en;
  wl_pkg::buf_adr_t     buf_wr_adr;
  logic [WORD_BITS-1:0] buf_wr_data;

  // reader to bank
  logic                 buf_rd_en;
  wl_pkg::buf_adr_t     buf_rd_adr;
  logic [WORD_BITS-1:0] buf_rd_data;

  weight_fetch_ctrl #(
    .DDR_CREDITS (DDR_CREDITS)
  ) i_fetch (
    .clk          (clk),
    .reset        (reset),
    .load_start   (load_start),
    .base_adr     (base_adr),
    .num_words    (num_words),
    .ddr_credit   (ddr_credit),
    .ddr_rd_valid (ddr_rd_valid),
    .ddr_rd_data  (ddr_rd_data),
    .ddr_rd_en    (ddr_rd_en),
    .ddr_rd_adr   (ddr_rd_adr),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_adr   (buf_wr_adr),
    .buf_wr_data  (buf_wr_data),
    .load_busy    (load_busy),
    .load_done    (load_done)
  );

  weight_pingpong_bank #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_bank (
    .clk         (clk),
    .reset       (reset),
    .load_start  (load_start),
    .buf_wr_en   (buf_wr_en),
    .buf_wr_adr  (buf_wr_adr),
    .buf_wr_data (buf_wr_data),
    .buf_rd_en   (buf_rd_en),
    .buf_rd_adr  (buf_rd_adr),
    .buf_rd_data (buf_rd_data)
  );

  weight_stream_reader #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_reader (
    .clk            (clk),
    .reset          (reset),
    .re_fm_en       (re_fm_en),
    .re_fm_end      (re_fm_end),
    .buf_rd_data    (buf_rd_data),
    .buf_rd_en      (buf_rd_en),
    .buf_rd_adr     (buf_rd_adr),
    .weights_vector (weights_vector),
    .weights_valid  (weights_valid)
  );

endmodule

// ==== hw/weight_stream_reader.sv ====
`timescale 1ns/1ps

module weight_stream_reader #(
  parameter int BANK_DEPTH = 1024
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 re_fm_en,       // one step per feature-map cycle
  input  logic                 re_fm_end,      // last step of the pass
  input  wl_pkg::weight_word_t buf_rd_data,    // drain bank, one cycle after read
  output logic                 buf_rd_en,
  output wl_pkg::buf_adr_t     buf_rd_adr,
  output wl_pkg::weight_word_t weights_vector, // to the PEs
  output logic                 weights_valid
);

  localparam wl_pkg::buf_adr_t LAST_ADR = wl_pkg::buf_adr_t'(BANK_DEPTH - 1);

  wl_pkg::buf_adr_t step_adr;  // next word to read

  //////////////////////////////////////////////////////////////////////
  // step address
  //////////////////////////////////////////////////////////////////////

  assign buf_rd_en  = re_fm_en;   // every step reads, no stall
  assign buf_rd_adr = step_adr;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      step_adr <= '0;
    end
    else if (re_fm_en)
    begin
      if (re_fm_end || (step_adr == LAST_ADR))
      begin
        step_adr <= '0;            // pass over, restart at word 0
      end
      else
      begin
        step_adr <= step_adr + 1'b1;
      end
    end
  end

  // valid trails the read by one cycle, back-to-back steps overlap
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      weights_valid <= 1'b0;
    end
    else
    begin
      weights_valid <= re_fm_en;
    end
  end

  assign weights_vector = buf_rd_data; // bank read register holds the vector

  a_end_with_step: assert property (@(posedge clk) disable iff (reset)
    re_fm_end |-> re_fm_en);

endmodule

// ==== hw/weight_pingpong_bank.sv ====
`timescale 1ns/1ps

module weight_pingpong_bank #(
  parameter int BANK_DEPTH = 1024
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_start,  // swaps fill and drain
  input  logic                 buf_wr_en,   // from fetch controller
  input  wl_pkg::buf_adr_t     buf_wr_adr,
  input  wl_pkg::weight_word_t buf_wr_data,
  input  logic                 buf_rd_en,   // from stream reader
  input  wl_pkg::buf_adr_t     buf_rd_adr,
  output wl_pkg::weight_word_t buf_rd_data
);

  logic fill_sel;   // bank being loaded, the other one drains
  logic rd_sel_q;   // bank that served the read in flight

  //////////////////////////////////////////////////////////////////////
  // fill select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fill_sel <= 1'b1;                          // first load lands in bank 0
    end
    else if (load_start)
    begin
      fill_sel <= ~fill_sel;                     // filled bank turns drain
    end
  end

  // remember the source bank, fill_sel may flip under a read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_sel_q <= 1'b0;
    end
    else if (buf_rd_en)
    begin
      rd_sel_q <= ~fill_sel;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // two single-port banks
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    wl_pkg::weight_word_t mem [BANK_DEPTH];  // inferred ram
    wl_pkg::weight_word_t rd_q;              // registered read port
    wl_pkg::buf_adr_t     adr;               // single shared port address
    logic                 is_fill;

    assign is_fill = (fill_sel == 1'(b));
    assign adr     = is_fill ? buf_wr_adr : buf_rd_adr;  // fill side writes, drain side reads

    always_ff @(posedge clk)
    begin
      if (is_fill && buf_wr_en)
      begin
        mem[adr] <= buf_wr_data;
      end
      else if (!is_fill && buf_rd_en)
      begin
        rd_q <= mem[adr];                      // data one cycle later
      end
    end
  end

  assign buf_rd_data = rd_sel_q ? g_bank[1].rd_q : g_bank[0].rd_q;

  // a tile longer than a bank would wrap onto its own head
  a_wr_in_range: assert property (@(posedge clk) disable iff (reset)
    buf_wr_en |-> (int'(buf_wr_adr) < BANK_DEPTH));

endmodule

// ==== hw/weight_fetch_ctrl.sv ====
`timescale 1ns/1ps

module weight_fetch_ctrl #(
  parameter int DDR_CREDITS = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_start,   // one-cycle start pulse
  input  wl_pkg::ddr_adr_t     base_adr,     // sampled at load_start
  input  wl_pkg::word_cnt_t    num_words,    // sampled at load_start
  input  logic                 ddr_credit,   // one credit back
  input  logic                 ddr_rd_valid, // read data, in request order
  input  wl_pkg::weight_word_t ddr_rd_data,
  output logic                 ddr_rd_en,
  output wl_pkg::ddr_adr_t     ddr_rd_adr,
  output logic                 buf_wr_en,    // write into fill bank
  output wl_pkg::buf_adr_t     buf_wr_adr,
  output wl_pkg::weight_word_t buf_wr_data,
  output logic                 load_busy,
  output logic                 load_done
);

  localparam int               CRD_W   = $clog2(DDR_CREDITS + 1);
  localparam logic [CRD_W-1:0] CRD_MAX = CRD_W'(DDR_CREDITS);

  wl_pkg::fetch_state_t state;
  wl_pkg::word_cnt_t    num_words_q;  // tile length of current load
  wl_pkg::word_cnt_t    req_cnt;      // requests issued so far
  wl_pkg::word_cnt_t    ret_cnt;      // words written so far
  logic [CRD_W-1:0]     credits;      // requests we may still issue
  logic                 last_req;
  logic                 last_ret;

  // issue while words remain and a credit is in hand
  assign ddr_rd_en = (state == wl_pkg::FETCH) && (credits != '0) &&
                     (req_cnt != num_words_q);
  assign last_req  = ddr_rd_en && (req_cnt + 1'b1 == num_words_q);

  // returned data goes straight into the fill bank
  assign buf_wr_en   = ddr_rd_valid && (state != wl_pkg::IDLE);
  assign buf_wr_adr  = wl_pkg::buf_adr_t'(ret_cnt);  // bank address 0 onward
  assign buf_wr_data = ddr_rd_data;
  assign last_ret    = buf_wr_en && (ret_cnt + 1'b1 == num_words_q);

  assign load_busy = (state != wl_pkg::IDLE);

  //////////////////////////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= wl_pkg::IDLE;
    end
    else
    begin
      unique case (state)
        wl_pkg::IDLE:
        begin
          if (load_start)
          begin
            state <= wl_pkg::FETCH;               // first request next cycle
          end
        end
        wl_pkg::FETCH:
        begin
          if (last_req)
          begin
            state <= wl_pkg::DRAIN;               // wait for the tail of data
          end
        end
        wl_pkg::DRAIN:
        begin
          if (last_ret)
          begin
            state <= wl_pkg::IDLE;
          end
        end
        default: state <= wl_pkg::IDLE;
      endcase
    end
  end

  // request, return and credit counters
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      req_cnt   <= '0;
      ret_cnt   <= '0;
      credits   <= CRD_MAX;                       // full pool after reset
      load_done <= 1'b0;
    end
    else
    begin
      if (load_start)
      begin
        req_cnt <= '0;
        ret_cnt <= '0;
      end
      else
      begin
        req_cnt <= req_cnt + wl_pkg::word_cnt_t'(ddr_rd_en);
        ret_cnt <= ret_cnt + wl_pkg::word_cnt_t'(buf_wr_en);
      end
      credits   <= credits + CRD_W'(ddr_credit) - CRD_W'(ddr_rd_en); // spend and return cancel
      load_done <= last_ret;                      // one cycle after the last write
    end
  end

  // tile parameters and running ddr address
  always_ff @(posedge clk)
  begin
    if (load_start)
    begin
      num_words_q <= num_words;
      ddr_rd_adr  <= base_adr;
    end
    else if (ddr_rd_en)
    begin
      ddr_rd_adr <= ddr_rd_adr + 1'b1;           // consecutive words
    end
  end

  // more credits back than handed out means the memory side miscounts
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credits <= CRD_MAX);

  a_valid_outstanding: assert property (@(posedge clk) disable iff (reset)
    ddr_rd_valid |-> (state != wl_pkg::IDLE) && (ret_cnt != req_cnt));

endmodule

// ==== hw/wl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// weight path widths and types
//////////////////////////////////////////////////////////////////////

package wl_pkg;

  // one weight word is 8 weights of 8 bits
  parameter int WORD_BITS = 64;

  typedef logic [15:0] ddr_adr_t;            // ddr word address
  typedef logic [9:0]  buf_adr_t;            // word address inside one bank
  typedef logic [10:0] word_cnt_t;           // tile length, 1 up to bank depth

  typedef logic [WORD_BITS-1:0] weight_word_t; // one weight word or vector

  //////////////////////////////////////////////////////////////////////
  // fetch controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,                                    // waiting for load_start
    FETCH,                                   // requests still to issue
    DRAIN                                    // all issued, data still returning
  } fetch_state_t;

endpackage
